// ==== Bender.yml ====
package:
  name: rap

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/rap_pkg.sv
      - source/rap_decoder.sv
      - source/rap_stack.sv
      - source/rap_predictor.sv
      - source/rap_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/rap_tb.sv

// ==== include/rap_cfg.svh ====
`ifndef RAP_CFG_SVH
`define RAP_CFG_SVH

// depth of the return address stack, any value of 2 or more works
`define RAP_NUM_ENTRY 8

// register numbers that RISC-V treats as link registers
`define RAP_LINK_RA 1
`define RAP_LINK_T0 5

`endif

// ==== rap_top.f ====
+incdir+include
source/rap_pkg.sv
source/rap_decoder.sv
source/rap_stack.sv
source/rap_predictor.sv
source/rap_top.sv
sim/rap_tb.sv

// ==== sim/rap_tb.sv ====
`include "rap_cfg.svh"

module rap_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM     = `RAP_NUM_ENTRY;
  localparam int TIMEOUT = 50;  // cycles allowed for any single wait

  logic            clk_i;
  logic            rst_ni;
  logic            wb_cyc_i;
  logic            wb_stb_i;
  logic            wb_we_i;
  rap_pkg::addr_t  wb_adr_i;
  rap_pkg::instr_t wb_dat_i;
  logic            wb_ack_o;
  rap_pkg::addr_t  wb_dat_o;
  logic            pred_valid_o;
  rap_pkg::pred_t  pred_o;
  logic            pred_ready_i;

  rap_pkg::addr_t  ref_stack [$];  // reference model with index 0 as the top
  logic [31:0]     lcg_state;
  int              check_cnt;
  int              err_cnt;
  int              test_cnt;
  int              check_mark;
  int              err_mark;

  rap_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .pred_valid_o (pred_valid_o),
    .pred_o       (pred_o),
    .pred_ready_i (pred_ready_i)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rap_pkg::instr_t enc_jal(logic [4:0] rd);
    return {20'h00100, rd, 7'b1101111};
  endfunction

  function automatic rap_pkg::instr_t enc_jalr(logic [4:0] rd, logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  function automatic rap_pkg::instr_t enc_addi(logic [4:0] rd, logic [4:0] rs1);
    return {12'h010, rs1, 3'b000, rd, 7'b0010011};  // never touches the stack
  endfunction

  // x1 and x5 are the only link registers
  function automatic rap_pkg::kind_e classify(rap_pkg::instr_t ins);
    logic rd_l;
    logic rs_l;
    rd_l = (ins[11:7] == 5'd1) || (ins[11:7] == 5'd5);
    rs_l = (ins[19:15] == 5'd1) || (ins[19:15] == 5'd5);
    if (ins[6:0] == 7'b1101111)
      return rd_l ? rap_pkg::KIND_CALL : rap_pkg::KIND_NONE;
    if (ins[6:0] != 7'b1100111)
      return rap_pkg::KIND_NONE;
    if (rd_l && (!rs_l || ins[11:7] == ins[19:15]))
      return rap_pkg::KIND_CALL;
    if (rd_l)
      return rap_pkg::KIND_SWAP;
    return rs_l ? rap_pkg::KIND_RET : rap_pkg::KIND_NONE;
  endfunction

  task automatic model_push(input rap_pkg::addr_t a);
    ref_stack.push_front(a);
    if (ref_stack.size() > NUM)
      void'(ref_stack.pop_back());  // oldest entry is lost
  endtask

  // builds the expected record from the top before the update, then updates
  task automatic model_step(input rap_pkg::addr_t pc, input rap_pkg::instr_t ins,
                            output rap_pkg::pred_t exp);
    rap_pkg::kind_e k;
    k = classify(ins);
    exp.pc           = pc;
    exp.kind         = k;
    exp.target_valid = 1'b0;
    exp.target       = '0;
    if ((k == rap_pkg::KIND_RET || k == rap_pkg::KIND_SWAP) && ref_stack.size() > 0) begin
      exp.target_valid = 1'b1;
      exp.target       = ref_stack[0];
    end
    if (k == rap_pkg::KIND_CALL) begin
      model_push(pc + 32'd4);
    end else if (k == rap_pkg::KIND_RET && ref_stack.size() > 0) begin
      void'(ref_stack.pop_front());
    end else if (k == rap_pkg::KIND_SWAP) begin
      if (ref_stack.size() > 0)
        ref_stack[0] = pc + 32'd4;
      else
        model_push(pc + 32'd4);
    end
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s within %0d cycles", what, TIMEOUT);
    $display("Regression failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("%-18s %0d checks, %0d errors", name, check_cnt - check_mark, err_cnt - err_mark);
    check_mark = check_cnt;
    err_mark   = err_cnt;
  endtask

  task automatic wb_start(input logic we, input rap_pkg::addr_t adr, input rap_pkg::instr_t dat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
  endtask

  // ack is looked at mid-cycle, the bus is released on the following edge
  task automatic wb_wait_ack(output rap_pkg::addr_t data);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!wb_ack_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!wb_ack_o)
      abort_on_timeout("no Wishbone ack");
    data = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input rap_pkg::addr_t pc, input rap_pkg::instr_t ins);
    rap_pkg::addr_t unused;
    wb_start(1'b1, pc, ins);
    wb_wait_ack(unused);
  endtask

  task automatic wb_read(output rap_pkg::addr_t data);
    wb_start(1'b0, '0, '0);
    wb_wait_ack(data);
  endtask

  // ready is held high for exactly one cycle once a record is seen
  task automatic collect(output rap_pkg::pred_t rec);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!pred_valid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!pred_valid_o)
      abort_on_timeout("no prediction record");
    rec = pred_o;
    @(posedge clk_i);
    pred_ready_i <= 1'b1;
    @(posedge clk_i);
    pred_ready_i <= 1'b0;
  endtask

  task automatic run_instr(input rap_pkg::addr_t pc, input rap_pkg::instr_t ins,
                           output rap_pkg::pred_t got);
    rap_pkg::pred_t exp;
    model_step(pc, ins, exp);
    wb_write(pc, ins);
    collect(got);
    check("pred_o", got, exp);
  endtask

  task automatic test_reset();
    rap_pkg::addr_t d;
    @(negedge clk_i);
    check("pred_valid_o", pred_valid_o, 1'b0);
    check("wb_ack_o", wb_ack_o, 1'b0);
    wb_read(d);
    check("wb_dat_o", d, 32'h0);
    end_test("reset");
  endtask

  task automatic test_call_return();
    rap_pkg::pred_t got;
    rap_pkg::addr_t d;
    run_instr(32'h0000_0400, enc_jal(5'd1), got);
    run_instr(32'h0000_0800, enc_jalr(5'd0, 5'd1), got);
    check("pred_o.kind", got.kind, rap_pkg::KIND_RET);
    check("pred_o.target_valid", got.target_valid, 1'b1);
    check("pred_o.target", got.target, 32'h0000_0404);
    wb_read(d);
    check("wb_dat_o", d, 32'h0);
    end_test("call_return");
  endtask

  task automatic test_nested();
    rap_pkg::pred_t got;
    rap_pkg::addr_t calls [$];
    for (int i = 0; i < NUM + 2; i++) begin
      calls.push_back(32'h0000_1000 + 32'(i * 16));
      run_instr(calls[i], enc_jal(5'd1), got);
    end
    for (int j = 0; j < NUM + 2; j++) begin
      run_instr(32'h0000_3000 + 32'(j * 8), enc_jalr(5'd0, 5'd1), got);
      if (j < NUM) begin
        check("pred_o.target_valid", got.target_valid, 1'b1);
        check("pred_o.target", got.target, calls[NUM + 1 - j] + 32'd4);
      end else begin
        check("pred_o.target_valid", got.target_valid, 1'b0);  // two oldest calls were dropped
      end
    end
    end_test("nested");
  endtask

  task automatic test_swap();
    rap_pkg::pred_t got;
    rap_pkg::addr_t d;
    run_instr(32'h0000_2000, enc_jal(5'd1), got);
    run_instr(32'h0000_2100, enc_jalr(5'd1, 5'd5), got);
    check("pred_o.kind", got.kind, rap_pkg::KIND_SWAP);
    check("pred_o.target", got.target, 32'h0000_2004);
    wb_read(d);
    check("wb_dat_o", d, 32'h0000_2104);
    run_instr(32'h0000_2200, enc_addi(5'd1, 5'd5), got);
    check("pred_o.kind", got.kind, rap_pkg::KIND_NONE);
    run_instr(32'h0000_2204, enc_jal(5'd0), got);
    check("pred_o.kind", got.kind, rap_pkg::KIND_NONE);
    run_instr(32'h0000_2208, enc_jalr(5'd6, 5'd7), got);
    check("pred_o.kind", got.kind, rap_pkg::KIND_NONE);
    wb_read(d);
    check("wb_dat_o", d, 32'h0000_2104);
    end_test("swap");
  endtask

  task automatic test_backpressure();
    rap_pkg::pred_t exp1;
    rap_pkg::pred_t exp2;
    rap_pkg::pred_t got;
    rap_pkg::addr_t d;
    model_step(32'h0000_5000, enc_jal(5'd5), exp1);
    model_step(32'h0000_6000, enc_jalr(5'd0, 5'd5), exp2);
    wb_write(32'h0000_5000, enc_jal(5'd5));
    wb_start(1'b1, 32'h0000_6000, enc_jalr(5'd0, 5'd5));
    repeat (6) begin
      @(negedge clk_i);  // output register is full, so the second write must stall
      check("wb_ack_o", wb_ack_o, 1'b0);
      check("pred_valid_o", pred_valid_o, 1'b1);
      check("pred_o", pred_o, exp1);
    end
    collect(got);
    check("pred_o", got, exp1);
    wb_wait_ack(d);
    collect(got);
    check("pred_o", got, exp2);
    check("pred_o.target", got.target, 32'h0000_5004);
    end_test("backpressure");
  endtask

  // mostly link registers so that every kind shows up often
  function automatic logic [4:0] pick_reg(logic [3:0] sel);
    if (sel < 4'd5)
      return 5'd1;
    if (sel < 4'd9)
      return 5'd5;
    return 5'(sel) + 5'd10;
  endfunction

  task automatic test_random();
    rap_pkg::pred_t  got;
    rap_pkg::instr_t ins;
    rap_pkg::addr_t  pc;
    logic [31:0]     r;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    for (int n = 0; n < 200; n++) begin
      r   = lcg_next();
      rd  = pick_reg(r[19:16]);
      rs1 = pick_reg(r[23:20]);
      case (r[25:24])
        2'd0:    ins = enc_jal(rd);
        2'd3:    ins = enc_addi(rd, rs1);
        default: ins = enc_jalr(rd, rs1);
      endcase
      r  = lcg_next();
      pc = {r[31:2], 2'b00};
      run_instr(pc, ins, got);
    end
    end_test("random");
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    pred_ready_i = 1'b0;
    lcg_state    = 32'h1965_6b50;
    check_cnt    = 0;
    err_cnt      = 0;
    test_cnt     = 0;
    check_mark   = 0;
    err_mark     = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_call_return();
    test_nested();
    test_swap();
    test_backpressure();
    test_random();
    $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== source/rap_decoder.sv ====
`include "rap_cfg.svh"

module rap_decoder (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  rap_pkg::addr_t  wb_adr_i,
  input  rap_pkg::instr_t wb_dat_i,
  output logic            wb_ack_o,
  output rap_pkg::addr_t  wb_dat_o,
  input  logic            peek_valid_i,
  input  rap_pkg::addr_t  peek_addr_i,
  output logic            push_o,
  output logic            pop_o,
  output rap_pkg::addr_t  push_addr_o,
  output logic            req_valid_o,
  output rap_pkg::req_t   req_o,
  input  logic            req_ready_i
);

  localparam logic [6:0] opc_jal  = 7'b1101111;
  localparam logic [6:0] opc_jalr = 7'b1100111;

  rap_pkg::dec_state_e state_q, state_d;
  rap_pkg::addr_t      pc_q;
  rap_pkg::instr_t     instr_q;
  rap_pkg::addr_t      rdata_q;
  rap_pkg::kind_e      kind;
  logic                start;
  logic                fire;
  logic [6:0]          opcode;
  logic [4:0]          rd;
  logic [4:0]          rs1;
  logic                rd_link;
  logic                rs1_link;

  function automatic logic is_link(logic [4:0] r);
    return (r == 5'(`RAP_LINK_RA)) || (r == 5'(`RAP_LINK_T0));
  endfunction

  assign opcode   = instr_q[6:0];
  assign rd       = instr_q[11:7];
  assign rs1      = instr_q[19:15];
  assign rd_link  = is_link(rd);
  assign rs1_link = is_link(rs1);

  // classification only looks at opcode, rd and rs1
  always_comb begin
    kind = rap_pkg::KIND_NONE;
    if (opcode == opc_jal) begin
      if (rd_link)
        kind = rap_pkg::KIND_CALL;
    end else if (opcode == opc_jalr) begin
      if (rd_link && (!rs1_link || rs1 == rd))
        kind = rap_pkg::KIND_CALL;
      else if (!rd_link && rs1_link)
        kind = rap_pkg::KIND_RET;
      else if (rd_link && rs1_link)
        kind = rap_pkg::KIND_SWAP;  // rd and rs1 are different link registers
    end
  end

  assign start = (state_q == rap_pkg::DEC_IDLE) && wb_cyc_i && wb_stb_i;
  assign fire  = req_valid_o && req_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      rap_pkg::DEC_IDLE: begin
        if (wb_cyc_i && wb_stb_i)
          state_d = wb_we_i ? rap_pkg::DEC_HOLD : rap_pkg::DEC_ACK;  // reads skip the hold
      end
      rap_pkg::DEC_HOLD: begin
        if (req_ready_i)
          state_d = rap_pkg::DEC_ACK;
      end
      default: state_d = rap_pkg::DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rap_pkg::DEC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      pc_q    <= wb_adr_i;
      instr_q <= wb_dat_i;
      if (!wb_we_i)
        rdata_q <= peek_valid_i ? peek_addr_i : '0;  // empty stack reads as zero
    end
  end

  assign wb_ack_o    = (state_q == rap_pkg::DEC_ACK);
  assign wb_dat_o    = rdata_q;
  assign req_valid_o = (state_q == rap_pkg::DEC_HOLD);
  assign req_o.pc    = pc_q;
  assign req_o.kind  = kind;

  // stack strobes last exactly the fire cycle
  assign push_o      = fire && (kind == rap_pkg::KIND_CALL || kind == rap_pkg::KIND_SWAP);
  assign pop_o       = fire && (kind == rap_pkg::KIND_RET || kind == rap_pkg::KIND_SWAP);
  assign push_addr_o = pc_q + 32'd4;

  // a stack strobe is the fire cycle, and the ack follows it directly
  strobe_in_fire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_o || pop_o) |=> (wb_ack_o && !push_o && !pop_o));

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== source/rap_pkg.sv ====
`include "rap_cfg.svh"

package rap_pkg;

  typedef logic [31:0] addr_t;   // rv32 only, so the width is fixed
  typedef logic [31:0] instr_t;  // one uncompressed instruction word

  // holds 0 through RAP_NUM_ENTRY
  typedef logic [$clog2(`RAP_NUM_ENTRY + 1)-1:0] depth_t;

  // what an instruction does to the return address stack
  typedef enum logic [1:0] {
    KIND_NONE,  // no stack operation
    KIND_CALL,  // push pc+4
    KIND_RET,   // pop
    KIND_SWAP   // pop and push pc+4 in one cycle
  } kind_e;

  // Wishbone slave sequencing in the decoder
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_HOLD,
    DEC_ACK
  } dec_state_e;

  // classified request from decoder to predictor
  typedef struct packed {
    addr_t pc;
    kind_e kind;
  } req_t;

  // prediction record on the output stream
  typedef struct packed {
    addr_t pc;
    kind_e kind;
    logic  target_valid;
    addr_t target;  // zero unless target_valid is set
  } pred_t;

endpackage

// ==== source/rap_predictor.sv ====
module rap_predictor (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  input  rap_pkg::req_t   req_i,
  output logic            req_ready_o,
  input  logic            peek_valid_i,
  input  rap_pkg::addr_t  peek_addr_i,
  output logic            pred_valid_o,
  output rap_pkg::pred_t  pred_o,
  input  logic            pred_ready_i
);

  logic           pred_valid_q;
  rap_pkg::pred_t pred_q;
  rap_pkg::pred_t pred_d;
  logic           fire;
  logic           has_target;

  // accept when empty or when the held record leaves this cycle
  assign req_ready_o = !pred_valid_q || pred_ready_i;
  assign fire        = req_valid_i && req_ready_o;

  assign has_target = (req_i.kind == rap_pkg::KIND_RET) || (req_i.kind == rap_pkg::KIND_SWAP);

  // peek is the stack top before this cycle's update
  always_comb begin
    pred_d.pc           = req_i.pc;
    pred_d.kind         = req_i.kind;
    pred_d.target_valid = has_target && peek_valid_i;
    pred_d.target       = (has_target && peek_valid_i) ? peek_addr_i : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pred_valid_q <= 1'b0;
    end else if (fire) begin
      pred_valid_q <= 1'b1;
    end else if (pred_ready_i) begin
      pred_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      pred_q <= pred_d;
    end
  end

  assign pred_valid_o = pred_valid_q;
  assign pred_o       = pred_q;

  // a stalled record must not change or disappear
  pred_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pred_valid_o && !pred_ready_i) |=> (pred_valid_o && $stable(pred_o)));

endmodule

// ==== source/rap_stack.sv ====
`include "rap_cfg.svh"

module rap_stack (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_i,
  input  logic           pop_i,
  input  rap_pkg::addr_t push_addr_i,
  output logic           peek_valid_o,
  output rap_pkg::addr_t peek_addr_o
);

  // entry 0 is the top of the stack
  logic [`RAP_NUM_ENTRY-1:0] valid_q, valid_d;
  rap_pkg::addr_t            addr_q [`RAP_NUM_ENTRY];
  rap_pkg::addr_t            addr_d [`RAP_NUM_ENTRY];
  rap_pkg::depth_t           fill_cnt;
  logic                      do_push;
  logic                      do_pop;
  logic                      do_swap;

  // a push-pop on an empty stack degrades into a plain push
  assign do_swap = push_i && pop_i && valid_q[0];
  assign do_push = push_i && !do_swap;
  assign do_pop  = pop_i && !push_i && valid_q[0];  // popping an empty stack is a no-op

  always_comb begin
    valid_d = valid_q;
    addr_d  = addr_q;
    if (do_push) begin
      // the bottom entry falls off when the stack is full
      valid_d   = {valid_q[`RAP_NUM_ENTRY-2:0], 1'b1};
      addr_d[0] = push_addr_i;
      for (int i = 1; i < `RAP_NUM_ENTRY; i++) begin
        addr_d[i] = addr_q[i-1];
      end
    end else if (do_pop) begin
      valid_d = {1'b0, valid_q[`RAP_NUM_ENTRY-1:1]};
      for (int i = 0; i < `RAP_NUM_ENTRY - 1; i++) begin
        addr_d[i] = addr_q[i+1];
      end
    end else if (do_swap) begin
      addr_d[0] = push_addr_i;  // coroutine swap replaces the top in place
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

  assign peek_valid_o = valid_q[0];
  assign peek_addr_o  = addr_q[0];

  // number of occupied entries
  always_comb begin
    fill_cnt = '0;
    for (int i = 0; i < `RAP_NUM_ENTRY; i++) begin
      fill_cnt = fill_cnt + rap_pkg::depth_t'(valid_q[i]);
    end
  end

  // occupied entries always form one run starting at the top
  valid_contiguous: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q == `RAP_NUM_ENTRY'((64'd1 << fill_cnt) - 64'd1));

endmodule

// ==== source/rap_top.sv ====
module rap_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  rap_pkg::addr_t  wb_adr_i,
  input  rap_pkg::instr_t wb_dat_i,
  output logic            wb_ack_o,
  output rap_pkg::addr_t  wb_dat_o,
  output logic            pred_valid_o,
  output rap_pkg::pred_t  pred_o,
  input  logic            pred_ready_i
);

  logic           push;
  logic           pop;
  rap_pkg::addr_t push_addr;
  logic           peek_valid;  // shared by decoder reads and predictor targets
  rap_pkg::addr_t peek_addr;
  logic           req_valid;
  rap_pkg::req_t  req;
  logic           req_ready;

  rap_decoder u_decoder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .peek_valid_i (peek_valid),
    .peek_addr_i  (peek_addr),
    .push_o       (push),
    .pop_o        (pop),
    .push_addr_o  (push_addr),
    .req_valid_o  (req_valid),
    .req_o        (req),
    .req_ready_i  (req_ready)
  );

  rap_stack u_stack (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .pop_i        (pop),
    .push_addr_i  (push_addr),
    .peek_valid_o (peek_valid),
    .peek_addr_o  (peek_addr)
  );

  rap_predictor u_predictor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .peek_valid_i (peek_valid),
    .peek_addr_i  (peek_addr),
    .pred_valid_o (pred_valid_o),
    .pred_o       (pred_o),
    .pred_ready_i (pred_ready_i)
  );

endmodule
